// ==== all.f ====
design/fpAddPkg.sv
design/fpAddIssue.sv
design/fpAddDecode.sv
design/fpAddExecute.sv
design/fpAddRound.sv
design/fpAddUnit.sv
verification/fpAddModel.sv
verification/fpAddTb.sv

// ==== Bender.yml ====
package:
  name: fpAdd

sources:
  - design/fpAddPkg.sv
  - design/fpAddIssue.sv
  - design/fpAddDecode.sv
  - design/fpAddExecute.sv
  - design/fpAddRound.sv
  - design/fpAddUnit.sv
  - target: test
    files:
      - verification/fpAddModel.sv
      - verification/fpAddTb.sv

// ==== verification/fpAddTb.sv ====
`timescale 1ns/1ps

module fpAddTb;
	localparam int RandomOps = 300;
	localparam int TieOps = 64;
	localparam int CancelOps = 60;
	localparam int OvfOps = 48;
	localparam int BackOps = 24;
	localparam int HoldCycles = 200;                 // Consumer withholds credits this long
	localparam int TotalOps = fpAddPkg::InFifoDepth + RandomOps + TieOps + CancelOps + 2
		+ OvfOps + BackOps;

	logic clk = 1'b0;
	logic arstN;
	logic inValid;
	fpAddPkg::fp16T inA;
	fpAddPkg::fp16T inB;
	logic inOp;
	logic outCredit;
	logic inCredit;
	logic outValid;
	fpAddPkg::fp16T outZ;
	logic outOvf;

	fpAddPkg::fp16T sendA[$];                        // Waiting for a driver credit
	fpAddPkg::fp16T sendB[$];
	logic sendOp[$];
	fpAddPkg::fp16T expZ[$];                         // Expected, issue order
	logic expOvf[$];
	int seed = 61584;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int sendCredits = fpAddPkg::InFifoDepth;
	int issuedCnt = 0;
	int receivedCnt = 0;
	int bufCount = 0;                                // Results held by the consumer
	int drainWait = 0;
	logic holdCredits = 1'b0;
	logic running = 1'b0;

	fpAddUnit i_dut (.clk, .arstN, .inValid, .inA, .inB, .inOp, .outCredit,
		.inCredit, .outValid, .outZ, .outOvf);

	always #5 clk = ~clk;

	task automatic checkFp16(input string name, input fpAddPkg::fp16T got, input fpAddPkg::fp16T want);
		if (got !== want) begin
			errors++;
			$display("Error %s: got 0x%04h expected 0x%04h", name, got, want);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want) begin
			errors++;
			$display("Error %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic queueOp(input fpAddPkg::fp16T a, input fpAddPkg::fp16T b, input logic op);
		fpAddPkg::fp16T z;
		logic ovf;
		fpAddModel::refAdd(a, b, op, z, ovf);
		sendA.push_back(a);
		sendB.push_back(b);
		sendOp.push_back(op);
		expZ.push_back(z);
		expOvf.push_back(ovf);
	endtask

	task automatic finishTest(input string name, input int nOps, input int startErr);
		while (sendA.size() != 0 || expZ.size() != 0) @(posedge clk);  // Watchdog bounds this
		testsRun++;
		if (errors != startErr) testsFailed++;
		$display("Test %s: %0d ops, %0d errors", name, nOps, errors - startErr);
	endtask

	// Sample at the falling edge, then drive the next inputs
	always @(negedge clk) begin
		if (running) begin
			if (inCredit) begin
				sendCredits++;                       // Pop returns a credit
				issuedCnt++;
			end
			if (outValid) begin
				if (receivedCnt >= issuedCnt || expZ.size() == 0) begin
					errors++;
					$display("A result arrived with no operation in flight");
				end else begin
					checkFp16("outZ", outZ, expZ.pop_front());
					checkFlag("outOvf", outOvf, expOvf.pop_front());
				end
				receivedCnt++;
				bufCount++;
			end
			outCredit = 1'b0;
			if (!holdCredits && bufCount > 0) begin
				if (drainWait == 0) begin
					outCredit = 1'b1;                // Free one buffer slot
					bufCount--;
					drainWait = $unsigned($random(seed)) % 4;
				end else begin
					drainWait--;
				end
			end
			if (issuedCnt - receivedCnt + bufCount > fpAddPkg::OutCreditInit) begin
				errors++;
				$display("More results outstanding than the consumer granted");
			end
			inValid = 1'b0;
			if (sendA.size() > 0 && sendCredits > 0) begin
				inValid = 1'b1;                      // Only with a credit in hand
				inA = sendA.pop_front();
				inB = sendB.pop_front();
				inOp = sendOp.pop_front();
				sendCredits--;
			end
		end
	end

	initial begin
		fpAddPkg::fp16T a;
		fpAddPkg::fp16T b;
		int e;
		int startErr;
		arstN = 1'b0;
		inValid = 1'b0;
		inA = '0;
		inB = '0;
		inOp = 1'b0;
		outCredit = 1'b0;
		repeat (10) begin
			@(negedge clk);
			checkFlag("inCredit", inCredit, 1'b0);
			checkFlag("outValid", outValid, 1'b0);
		end
		arstN = 1'b1;
		@(posedge clk);
		checkFlag("inCredit", inCredit, 1'b0);       // FIFO empty after reset
		checkFlag("outValid", outValid, 1'b0);
		running = 1'b1;
		for (int i = 0; i < fpAddPkg::InFifoDepth; i++) begin
			queueOp(fpAddModel::randNormal(seed), fpAddModel::randNormal(seed), 1'(i));
		end
		finishTest("reset", fpAddPkg::InFifoDepth, 0);

		startErr = errors;
		for (int i = 0; i < RandomOps; i++) begin
			a = fpAddModel::randNormal(seed);
			b = fpAddModel::randNormal(seed);
			if (i % 2 == 0) b[14:10] = a[14:10];     // Equal scale, deep cancellation
			queueOp(a, b, 1'($random(seed)));
		end
		finishTest("random", RandomOps, startErr);

		// B is half an ulp of A, nudged above half every third op
		startErr = errors;
		for (int i = 0; i < TieOps; i++) begin
			e = 12 + $unsigned($random(seed)) % 19;
			a = {1'($random(seed)), 5'(e), (i % 4 == 0) ? 10'h3ff : 10'($random(seed))};
			b = {1'($random(seed)), 5'(e - 11), (i % 3 == 0) ? 10'h001 : 10'h000};
			queueOp(a, b, 1'(i));
		end
		finishTest("ties", TieOps, startErr);

		startErr = errors;
		for (int i = 0; i < CancelOps; i++) begin
			a = fpAddModel::randNormal(seed);
			case (i % 6)
				0: queueOp(a, a, 1'b1);
				1: queueOp({~a[15], a[14:0]}, a, 1'b0);
				2: queueOp(a, {a[15:10], a[9:0] + 10'd1}, 1'b1);
				3: queueOp(a, {a[15], a[14:10] - 5'd1, a[9:0]}, 1'b1);
				4: queueOp({a[15], 5'd0, a[9:0]}, a, 1'($random(seed)));  // Subnormal input
				default: queueOp({a[15], 5'd1, a[9:0]}, {a[15], 5'd1, 10'($random(seed))}, 1'b1);
			endcase
		end
		queueOp(16'h8000, 16'h0000, 1'b1);           // -0 minus +0
		queueOp(16'h8001, 16'h8200, 1'b0);
		finishTest("cancel", CancelOps + 2, startErr);

		startErr = errors;
		for (int i = 0; i < OvfOps; i++) begin
			a = fpAddModel::randNormal(seed);
			b = fpAddModel::randNormal(seed);
			a[14:10] = 5'd28 + 5'(i % 3);
			b[14:10] = 5'd30 - 5'(i % 2);
			queueOp(a, b, (i % 4 == 3) ? ~(a[15] ^ b[15]) : (a[15] ^ b[15]));
		end
		finishTest("overflow", OvfOps, startErr);

		startErr = errors;
		holdCredits = 1'b1;
		for (int i = 0; i < BackOps; i++) begin
			queueOp(fpAddModel::randNormal(seed), fpAddModel::randNormal(seed), 1'(i));
		end
		repeat (HoldCycles) @(posedge clk);
		if (sendA.size() == 0) begin
			errors++;
			$display("The driver was not stalled while credits were withheld");
		end
		holdCredits = 1'b0;
		finishTest("backpressure", BackOps, startErr);

		$display("Tests %0d, failed %0d, results %0d, errors %0d",
			testsRun, testsFailed, receivedCnt, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (TotalOps * 40 + 1000) @(posedge clk);
		$display("Run timed out with %0d of %0d results received", receivedCnt, TotalOps);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verification/fpAddModel.sv ====
package fpAddModel;

	// Exact sum of the flushed operands, one rounding to nearest even
	function automatic void refAdd(input fpAddPkg::fp16T a, input fpAddPkg::fp16T b,
		input logic op, output fpAddPkg::fp16T z, output logic ovf);
		int eA;
		int eB;
		int eMin;
		int e;
		int p;
		longint mA;
		longint mB;
		longint sum;                                 // Signed, units of 2^(eMin-25)
		longint mag;
		longint q;
		longint rem;
		longint half;
		logic sA;
		logic sB;
		sA = a[15];
		sB = b[15] ^ op;                             // Subtract flips B
		eA = (a[14:10] == 0) ? int'(b[14:10]) : int'(a[14:10]);  // Zero borrows the other scale
		eB = (b[14:10] == 0) ? eA : int'(b[14:10]);
		eMin = (eA < eB) ? eA : eB;
		mA = (a[14:10] == 0) ? 0 : longint'({1'b1, a[9:0]}) << (eA - eMin);
		mB = (b[14:10] == 0) ? 0 : longint'({1'b1, b[9:0]}) << (eB - eMin);
		sum = (sA ? -mA : mA) + (sB ? -mB : mB);
		ovf = 1'b0;
		z = {sA & sB, 15'h0};                        // Zero is negative only if both addends are
		if (sum == 0) return;
		mag = (sum < 0) ? -sum : sum;
		p = 0;
		for (int i = 0; i < 48; i++) begin
			if (mag[i]) p = i;                       // Leading one
		end
		e = p + eMin - 10;                           // Biased exponent before rounding
		if (p > 10) begin
			q = mag >> (p - 10);                     // Keep 11 significant bits
			rem = mag - (q << (p - 10));
			half = longint'(1) << (p - 11);
			if (rem > half || (rem == half && q[0])) q++;
			if (q == 2048) begin
				q = 1024;                            // Carry out of the significand
				e++;
			end
		end else begin
			q = mag << (10 - p);                     // Exact, no rounding
		end
		if (e >= 31) begin
			ovf = 1'b1;
			z = {sum < 0, 5'h1f, 10'h0};
		end else if (e >= 1) begin
			z = {sum < 0, 5'(e), 10'(q)};            // Hidden bit dropped
		end
	endfunction

	// Normal operand, exponent 1 to 30
	function automatic fpAddPkg::fp16T randNormal(inout int seed);
		int r;
		int e;
		r = $random(seed);
		e = 1 + int'(r[30:16]) % 30;
		return {r[31], 5'(e), r[9:0]};
	endfunction

endpackage

// ==== design/fpAddUnit.sv ====
`timescale 1ns/1ps

module fpAddUnit (
	input  logic           clk,
	input  logic           arstN,
	input  logic           inValid,
	input  fpAddPkg::fp16T inA,
	input  fpAddPkg::fp16T inB,
	input  logic           inOp,       // 1 subtracts
	input  logic           outCredit,  // One result slot freed
	output logic           inCredit,   // One input slot freed
	output logic           outValid,   // Three cycles after issue
	output fpAddPkg::fp16T outZ,
	output logic           outOvf
);
	// Issue to decode
	logic issueValid;
	fpAddPkg::fp16T issueA;
	fpAddPkg::fp16T issueB;
	logic issueOp;

	// Decode to execute
	logic decValid;
	logic decSignA;
	logic decSignB;
	logic decEffSub;
	logic decAGreater;
	fpAddPkg::expT decExp;
	fpAddPkg::manT decManBig;
	fpAddPkg::alignT decManSmall;

	// Execute to round
	logic exeValid;
	logic exeZero;
	logic exeSignA;
	logic exeSignB;
	logic exeEffSub;
	logic exeAGreater;
	fpAddPkg::expT exeNormE;
	logic [fpAddPkg::ManWidth-1:0] exeNormM;
	logic exeG;
	logic exeR;
	logic exeS;

	fpAddIssue i_issue (
		.clk, .arstN, .inValid, .inA, .inB, .inOp, .outCredit,
		.inCredit, .issueValid, .issueA, .issueB, .issueOp
	);

	fpAddDecode i_decode (
		.clk, .arstN, .issueValid, .issueA, .issueB, .issueOp,
		.decValid, .decSignA, .decSignB, .decEffSub, .decAGreater,
		.decExp, .decManBig, .decManSmall
	);

	fpAddExecute i_execute (
		.clk, .arstN, .decValid, .decSignA, .decSignB, .decEffSub, .decAGreater,
		.decExp, .decManBig, .decManSmall,
		.exeValid, .exeZero, .exeSignA, .exeSignB, .exeEffSub, .exeAGreater,
		.exeNormE, .exeNormM, .exeG, .exeR, .exeS
	);

	fpAddRound i_round (
		.clk, .arstN, .exeValid, .exeZero, .exeSignA, .exeSignB, .exeEffSub,
		.exeAGreater, .exeNormE, .exeNormM, .exeG, .exeR, .exeS,
		.outValid, .outZ, .outOvf
	);

endmodule

// ==== design/fpAddRound.sv ====
`timescale 1ns/1ps

module fpAddRound (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          exeValid,
	input  logic                          exeZero,
	input  logic                          exeSignA,
	input  logic                          exeSignB,     // Effective sign of B
	input  logic                          exeEffSub,
	input  logic                          exeAGreater,
	input  fpAddPkg::expT                 exeNormE,
	input  logic [fpAddPkg::ManWidth-1:0] exeNormM,
	input  logic                          exeG,
	input  logic                          exeR,
	input  logic                          exeS,
	output logic                          outValid,
	output fpAddPkg::fp16T                outZ,
	output logic                          outOvf        // Exponent overflow
);
	logic [fpAddPkg::ManWidth:0] roundUpM;              // Extra bit catches the carry
	logic [fpAddPkg::ManWidth-1:0] roundM;
	fpAddPkg::expT roundE;
	logic roundUp;
	logic roundCarry;
	logic resSign;
	logic ovf;

	// Above half, or exactly half with odd lsb
	assign roundUp = exeG & (exeR | exeS | exeNormM[0]);
	assign roundUpM = {1'b0, exeNormM} + 1'b1;
	assign roundM = roundUp ? roundUpM[fpAddPkg::ManWidth-1:0] : exeNormM;
	assign roundCarry = roundUp & roundUpM[fpAddPkg::ManWidth];  // Mantissa wrapped to 0
	assign roundE = exeNormE + fpAddPkg::expT'(roundCarry);

	// Zero is negative only when both addends are
	assign resSign = exeZero ? (~exeEffSub & exeSignA)
		: (exeAGreater ? exeSignA : exeSignB);

	assign ovf = ~exeZero & (roundE >= fpAddPkg::ExpInf);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= exeValid;
		end
	end

	always_ff @(posedge clk) begin
		if (exeValid) begin
			outOvf <= ovf;
			if (exeZero) begin
				outZ <= {resSign, {(fpAddPkg::DataWidth - 1){1'b0}}};
			end else if (ovf) begin
				outZ <= {resSign, {fpAddPkg::ExpWidth{1'b1}}, {fpAddPkg::ManWidth{1'b0}}};
			end else begin
				outZ <= {resSign, roundE[fpAddPkg::ExpWidth-1:0], roundM};
			end
		end
	end

	// Execute clears G, R, S on zero so rounding can't carry
	assert property (@(posedge clk) disable iff (!arstN) (exeValid && exeZero) |-> !roundCarry)
		else $error("fpAddRound rounding carry on zero sum");

endmodule

// ==== design/fpAddExecute.sv ====
`timescale 1ns/1ps

module fpAddExecute (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          decValid,
	input  logic                          decSignA,
	input  logic                          decSignB,
	input  logic                          decEffSub,
	input  logic                          decAGreater,
	input  fpAddPkg::expT                 decExp,
	input  fpAddPkg::manT                 decManBig,
	input  fpAddPkg::alignT               decManSmall,
	output logic                          exeValid,
	output logic                          exeZero,      // Zero sum or flushed result
	output logic                          exeSignA,
	output logic                          exeSignB,
	output logic                          exeEffSub,
	output logic                          exeAGreater,
	output fpAddPkg::expT                 exeNormE,     // Normalized exponent
	output logic [fpAddPkg::ManWidth-1:0] exeNormM,     // Hidden bit dropped
	output logic                          exeG,         // Guard
	output logic                          exeR,         // Round
	output logic                          exeS          // Sticky
);
	fpAddPkg::alignT bigExt;
	fpAddPkg::alignT sum;
	logic [fpAddPkg::ManWidth+3:0] normShift;          // Sum below the carry, left aligned
	logic [3:0] lzCnt;                                  // Leading zeros below the carry
	logic carry;
	logic exactZero;
	logic underflow;
	fpAddPkg::expT normE;
	logic [fpAddPkg::ManWidth-1:0] normM;
	logic g;
	logic r;
	logic s;

	// Big is never below small, so the difference stays positive
	assign bigExt = {1'b0, decManBig, 3'b000};
	assign sum = decEffSub ? (bigExt - decManSmall) : (bigExt + decManSmall);
	assign carry = sum[fpAddPkg::ManWidth+4];
	assign exactZero = (sum == '0);

	// Highest set bit wins
	always_comb begin
		lzCnt = '0;
		for (int i = 0; i < fpAddPkg::ShiftMax; i++) begin
			if (sum[i]) begin
				lzCnt = 4'(fpAddPkg::ShiftMax - 1 - i);
			end
		end
	end

	assign normShift = sum[fpAddPkg::ManWidth+3:0] << lzCnt;

	// Exponent would drop below 1
	assign underflow = !carry && !exactZero && (decExp <= fpAddPkg::expT'(lzCnt));

	always_comb begin
		if (carry) begin
			normE = decExp + 1'b1;                    // One place right
			normM = sum[fpAddPkg::ManWidth+3:4];
			g = sum[3];
			r = sum[2];
			s = sum[1] | sum[0];                      // Lost bit joins sticky
		end else begin
			normE = decExp - fpAddPkg::expT'(lzCnt);
			normM = normShift[fpAddPkg::ManWidth+2:3];
			g = normShift[2];
			r = normShift[1];
			s = normShift[0];
		end
		if (exactZero || underflow) begin
			normE = '0;                               // Clean zero, no rounding
			normM = '0;
			g = 1'b0;
			r = 1'b0;
			s = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exeValid <= 1'b0;
		end else begin
			exeValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			exeZero <= exactZero | underflow;         // Flush shares the zero path
			exeSignA <= decSignA;
			exeSignB <= decSignB;
			exeEffSub <= decEffSub;
			exeAGreater <= decAGreater;
			exeNormE <= normE;
			exeNormM <= normM;
			exeG <= g;
			exeR <= r;
			exeS <= s;
		end
	end

endmodule

// ==== design/fpAddDecode.sv ====
`timescale 1ns/1ps

module fpAddDecode (
	input  logic            clk,
	input  logic            arstN,
	input  logic            issueValid,
	input  fpAddPkg::fp16T  issueA,
	input  fpAddPkg::fp16T  issueB,
	input  logic            issueOp,       // 1 subtracts
	output logic            decValid,
	output logic            decSignA,
	output logic            decSignB,      // Effective sign after op
	output logic            decEffSub,     // Signs differ
	output logic            decAGreater,   // |A| >= |B|
	output fpAddPkg::expT   decExp,        // Exponent of larger operand
	output fpAddPkg::manT   decManBig,
	output fpAddPkg::alignT decManSmall    // Aligned with guard, round, sticky
);
	logic [fpAddPkg::ExpWidth-1:0] expA;
	logic [fpAddPkg::ExpWidth-1:0] expB;
	logic [fpAddPkg::ExpWidth-1:0] expBig;
	logic [fpAddPkg::ExpWidth-1:0] expDiff;
	fpAddPkg::manT manA;
	fpAddPkg::manT manB;
	fpAddPkg::manT manBig;
	fpAddPkg::manT manSmall;
	logic signA;
	logic signB;
	logic aGreater;
	logic [3:0] shiftAmt;                            // Saturated alignment shift
	logic [fpAddPkg::ManWidth+3:0] smallExt;         // Small mantissa with three zero bits
	logic [fpAddPkg::ManWidth+3:0] smallShift;
	logic [fpAddPkg::ManWidth+3:0] lostMask;         // Bits pushed off the bottom
	logic sticky;
	fpAddPkg::alignT aligned;

	// Unpack
	assign expA = issueA[fpAddPkg::DataWidth-2 -: fpAddPkg::ExpWidth];
	assign expB = issueB[fpAddPkg::DataWidth-2 -: fpAddPkg::ExpWidth];
	assign signA = issueA[fpAddPkg::DataWidth-1];
	assign signB = issueB[fpAddPkg::DataWidth-1] ^ issueOp;  // Subtract flips B

	// Zero exponent field flushes to zero, hidden bit otherwise
	assign manA = (expA == '0) ? '0 : {1'b1, issueA[fpAddPkg::ManWidth-1:0]};
	assign manB = (expB == '0) ? '0 : {1'b1, issueB[fpAddPkg::ManWidth-1:0]};

	// Order by magnitude, exponent first then mantissa
	assign aGreater = ({expA, manA} >= {expB, manB});
	assign expBig = aGreater ? expA : expB;
	assign expDiff = aGreater ? (expA - expB) : (expB - expA);  // Never negative
	assign manBig = aGreater ? manA : manB;
	assign manSmall = aGreater ? manB : manA;

	// Past the window everything lands in sticky
	assign shiftAmt = (expDiff > fpAddPkg::ShiftMax) ? 4'(fpAddPkg::ShiftMax) : expDiff[3:0];

	assign smallExt = {manSmall, 3'b000};
	assign smallShift = smallExt >> shiftAmt;
	assign lostMask = ~({(fpAddPkg::ManWidth + 4){1'b1}} << shiftAmt);  // Low shiftAmt ones
	assign sticky = |(smallExt & lostMask);

	// Carry slot on top, lost bits folded into the bottom bit
	assign aligned = {1'b0, smallShift[fpAddPkg::ManWidth+3:1], smallShift[0] | sticky};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= issueValid;
		end
	end

	always_ff @(posedge clk) begin
		if (issueValid) begin
			decSignA <= signA;
			decSignB <= signB;
			decEffSub <= signA ^ signB;
			decAGreater <= aGreater;
			decExp <= {1'b0, expBig};                // Room for overflow later
			decManBig <= manBig;
			decManSmall <= aligned;
		end
	end

endmodule

// ==== design/fpAddIssue.sv ====
`timescale 1ns/1ps

module fpAddIssue (
	input  logic           clk,
	input  logic           arstN,
	input  logic           inValid,     // Push, sender holds a credit
	input  fpAddPkg::fp16T inA,
	input  fpAddPkg::fp16T inB,
	input  logic           inOp,        // 1 subtracts
	input  logic           outCredit,   // Consumer freed one result slot
	output logic           inCredit,    // Pop pulse, one credit back to sender
	output logic           issueValid,
	output fpAddPkg::fp16T issueA,
	output fpAddPkg::fp16T issueB,
	output logic           issueOp
);
	fpAddPkg::fp16T memA [fpAddPkg::InFifoDepth];    // Operand A storage
	fpAddPkg::fp16T memB [fpAddPkg::InFifoDepth];    // Operand B storage
	logic memOp [fpAddPkg::InFifoDepth];
	logic [fpAddPkg::FifoPtrWidth-1:0] wrPtr;
	logic [fpAddPkg::FifoPtrWidth-1:0] rdPtr;
	fpAddPkg::creditT fillCnt;                      // Entries held
	fpAddPkg::creditT creditCnt;                    // Free result slots downstream
	logic fifoFull;
	logic pop;

	assign fifoFull = (fillCnt == fpAddPkg::creditT'(fpAddPkg::InFifoDepth));
	assign pop = (fillCnt != '0) && (creditCnt != '0);  // Slot reserved before issue

	assign issueValid = pop;
	assign inCredit = pop;                          // Same cycle as the pop
	assign issueA = memA[rdPtr];                    // Head of FIFO
	assign issueB = memB[rdPtr];
	assign issueOp = memOp[rdPtr];

	always_ff @(posedge clk) begin
		if (inValid) begin
			memA[wrPtr] <= inA;
			memB[wrPtr] <= inB;
			memOp[wrPtr] <= inOp;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCnt <= '0;
			creditCnt <= fpAddPkg::creditT'(fpAddPkg::OutCreditInit);
		end else begin
			if (inValid) begin
				wrPtr <= wrPtr + 1'b1;                  // Wraps, depth is a power of two
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			fillCnt <= fillCnt + fpAddPkg::creditT'(inValid) - fpAddPkg::creditT'(pop);
			creditCnt <= creditCnt - fpAddPkg::creditT'(pop)
				+ fpAddPkg::creditT'(outCredit);          // Spend and return may coincide
		end
	end

	// Sender only pushes into space it was granted
	assert property (@(posedge clk) disable iff (!arstN) inValid |-> (!fifoFull || pop))
		else $error("fpAddIssue push while FIFO full");

	// Consumer never returns more slots than it was given
	assert property (@(posedge clk) disable iff (!arstN)
		creditCnt <= fpAddPkg::creditT'(fpAddPkg::OutCreditInit))
		else $error("fpAddIssue credit count above init");

endmodule

// ==== design/fpAddPkg.sv ====
package fpAddPkg;

	// FP16 field layout
	localparam int ExpWidth = 5;                  // Biased exponent field
	localparam int ManWidth = 10;                 // Stored mantissa, hidden bit excluded
	localparam int DataWidth = 16;                // Sign, exponent, mantissa
	localparam int ExpBias = 15;
	localparam int ExpInf = 2 * ExpBias + 1;      // All-ones exponent means infinity

	// Alignment window is hidden bit, mantissa and three extra bits
	localparam int ShiftMax = ManWidth + 4;       // Shift that empties the window

	// Flow control
	localparam int InFifoDepth = 4;               // Also the sender's starting credit
	localparam int FifoPtrWidth = $clog2(InFifoDepth);
	localparam int OutCreditInit = 4;             // Result slots granted at reset

	// Packed FP16 word
	typedef logic [DataWidth-1:0] fp16T;

	// Biased exponent plus one bit to catch overflow
	typedef logic [ExpWidth:0] expT;

	// Mantissa with hidden bit
	typedef logic [ManWidth:0] manT;

	// Carry, hidden bit, mantissa, guard, round, sticky
	typedef logic [ManWidth+4:0] alignT;

	// Holds 0 to OutCreditInit inclusive
	typedef logic [$clog2(OutCreditInit+1)-1:0] creditT;

endpackage
